// File: common/soc_pkg.sv
// shared types and constants; the io stub countdown needs IO_WAIT_CYCLES of at least 2
`default_nettype none

package soc_pkg;

    // data path widths
    localparam int WORD_W = 32;
    localparam int BYTE_LANES = WORD_W / 8;
    localparam int WORD_ADDR_W = 16;

    // one data word, used for write, read and fetch data
    typedef logic [WORD_W-1:0] word_t;

    // one enable bit per byte lane
    typedef logic [BYTE_LANES-1:0] byte_en_t;

    // word address, bit 15 picks the io region
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;

    // address map
    localparam int IO_SEL_BIT = 15;
    // io offset field is bits 13:0
    localparam int IO_OFFSET_W = 14;
    typedef logic [IO_OFFSET_W-1:0] io_offset_t;

    // default scratch ram depth in words
    // only low 10 bits index it, upper memory bits alias
    localparam int MEM_WORDS = 1024;

    // io stub timing and contents
    localparam int IO_WAIT_CYCLES = 5;
    localparam int IO_CNT_W = $clog2(IO_WAIT_CYCLES + 1);
    typedef logic [IO_CNT_W-1:0] io_cnt_t;

    // every io read returns this
    localparam word_t IO_READ_PATTERN = 32'hFFFFFF21;

    // io word offset that acts as the console byte port
    localparam io_offset_t UART_WORD_OFFSET = io_offset_t'(1024);

    // one host access, held stable while req is high
    typedef struct packed {
        word_addr_t addr;
        word_t      wdata;
        byte_en_t   be;
        // 1 for a write, 0 for a read
        logic       write;
    } bus_req_t;

    // controller to ram port b
    // a read is en with be all zero
    typedef struct packed {
        logic       en;
        word_addr_t addr;
        byte_en_t   be;
        word_t      wdata;
    } mem_port_t;

    // bus controller states
    // RESPOND latches the response, RELEASE holds ack until req drops
    typedef enum logic [2:0] {
        IDLE,
        MEM_WAIT,
        IO_WAIT,
        RESPOND,
        RELEASE
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: bram/byte_en_bram.sv
// DEPTH must be a power of two up to 2**15; contents start at zero, read-during-write gives old data
`timescale 1ns/1ns
`default_nettype none

module byte_en_bram #(
    parameter int DEPTH = soc_pkg::MEM_WORDS
) (
    input  wire logic               clk,

    // port a, read only fetch
    input  wire soc_pkg::word_addr_t addr_a,
    input  wire logic               en_a,
    output soc_pkg::word_t          data_out_a,

    // port b, read or byte-lane write
    input  wire soc_pkg::mem_port_t port_b,
    output soc_pkg::word_t          data_out_b
);

    localparam int IDX_W = $clog2(DEPTH);

    soc_pkg::word_t mem [DEPTH];

    logic [IDX_W-1:0] idx_a;
    logic [IDX_W-1:0] idx_b;

    // upper address bits alias
    assign idx_a = addr_a[IDX_W-1:0];
    assign idx_b = port_b.addr[IDX_W-1:0];

    // ram comes up cleared
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // port a, registered read
    always_ff @(posedge clk) begin
        if (en_a) begin
            data_out_a <= mem[idx_a];
        end
    end

    // port b, old data out, then lane writes
    always_ff @(posedge clk) begin
        if (port_b.en) begin
            data_out_b <= mem[idx_b];
            for (int lane = 0; lane < soc_pkg::BYTE_LANES; lane++) begin
                if (port_b.be[lane]) begin
                    mem[idx_b][lane*8 +: 8] <= port_b.wdata[lane*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/slow_io_target.sv
// io_done follows io_start by IO_WAIT_CYCLES edges; io_req must stay stable until io_done
`timescale 1ns/1ns
`default_nettype none

module slow_io_target (
    input  wire logic               clk,
    input  wire logic               rst,

    // from the bus controller
    input  wire logic               io_start,
    input  wire soc_pkg::bus_req_t  io_req,
    output logic                    io_done,
    output soc_pkg::word_t          io_rdata,

    // console byte strobe, no back-pressure
    output logic                    uart_valid,
    output logic [7:0]              uart_byte
);

    // countdown state
    logic             busy;
    soc_pkg::io_cnt_t cnt;

    // write hits the console offset
    logic uart_hit;

    assign uart_hit = io_req.write &&
        (io_req.addr[soc_pkg::IO_OFFSET_W-1:0] == soc_pkg::UART_WORD_OFFSET);

    // countdown and done strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            cnt        <= '0;
            io_done    <= 1'b0;
            uart_valid <= 1'b0;
        end else begin
            io_done    <= 1'b0;
            uart_valid <= 1'b0;
            if (io_start) begin
                // one edge already spent seeing the start pulse
                busy <= 1'b1;
                cnt  <= soc_pkg::io_cnt_t'(soc_pkg::IO_WAIT_CYCLES - 1);
            end else if (busy) begin
                if (cnt == soc_pkg::io_cnt_t'(1)) begin
                    busy       <= 1'b0;
                    io_done    <= 1'b1;
                    // console strobe lines up with io_done
                    uart_valid <= uart_hit;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    // response data, loaded with the done pulse
    always_ff @(posedge clk) begin
        if (busy && cnt == soc_pkg::io_cnt_t'(1)) begin
            // writes elsewhere are dropped, read value ignored for writes
            io_rdata  <= io_req.write ? '0 : soc_pkg::IO_READ_PATTERN;
            uart_byte <= io_req.wdata[7:0];
        end
    end

endmodule

`default_nettype wire

// File: source/bus_ctrl.sv
// one access at a time over a four-phase req/ack handshake; memory ack in 3 edges, io in IO_WAIT_CYCLES + 3
`timescale 1ns/1ns
`default_nettype none

module bus_ctrl (
    input  wire logic               clk,
    input  wire logic               rst,

    // host side, four-phase handshake
    input  wire logic               req,
    input  wire soc_pkg::bus_req_t  req_data,
    output logic                    ack,
    output soc_pkg::word_t          rdata,

    // scratch ram port b
    output soc_pkg::mem_port_t      mem_port,
    input  wire soc_pkg::word_t     mem_rdata,

    // slow io stub
    output logic                    io_start,
    output soc_pkg::bus_req_t       io_req,
    input  wire logic               io_done,
    input  wire soc_pkg::word_t     io_rdata
);

    soc_pkg::ctrl_state_t state;

    // request captured at the sampling edge
    soc_pkg::bus_req_t req_r;

    // ram enable pulse, one cycle after sampling
    logic mem_en;

    // new request seen in IDLE
    logic take;

    assign take = (state == soc_pkg::IDLE) && req && !ack;

    // control path
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= soc_pkg::IDLE;
            ack      <= 1'b0;
            io_start <= 1'b0;
            mem_en   <= 1'b0;
        end else begin
            // both starts are single-cycle pulses
            io_start <= 1'b0;
            mem_en   <= 1'b0;

            case (state)
                soc_pkg::IDLE: begin
                    if (take) begin
                        // region decode on address bit 15
                        if (req_data.addr[soc_pkg::IO_SEL_BIT]) begin
                            io_start <= 1'b1;
                            state    <= soc_pkg::IO_WAIT;
                        end else begin
                            mem_en <= 1'b1;
                            state  <= soc_pkg::MEM_WAIT;
                        end
                    end
                end

                // ram takes the port here, data shows up next cycle
                soc_pkg::MEM_WAIT: begin
                    state <= soc_pkg::RESPOND;
                end

                // stub holds io_rdata once io_done fires
                soc_pkg::IO_WAIT: begin
                    if (io_done) begin
                        state <= soc_pkg::RESPOND;
                    end
                end

                soc_pkg::RESPOND: begin
                    state <= soc_pkg::RELEASE;
                end

                // ack up while req is held, drop it once req goes low
                soc_pkg::RELEASE: begin
                    if (req) begin
                        ack <= 1'b1;
                    end else begin
                        ack   <= 1'b0;
                        state <= soc_pkg::IDLE;
                    end
                end

                default: begin
                    state <= soc_pkg::IDLE;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (take) begin
            req_r <= req_data;
        end
        // both sources hold their data by now
        if (state == soc_pkg::RESPOND) begin
            rdata <= req_r.addr[soc_pkg::IO_SEL_BIT] ? io_rdata : mem_rdata;
        end
    end

    // reads go out with no lanes enabled
    assign mem_port = '{
        en:    mem_en,
        addr:  req_r.addr,
        be:    req_r.write ? req_r.be : '0,
        wdata: req_r.wdata
    };

    // held from io_start through io_done
    assign io_req = req_r;

endmodule

`default_nettype wire

// File: source/sim_soc_top.sv
// sim harness top; fetch port reads ram port a directly and never stalls, RAM depth is MEM_WORDS
`timescale 1ns/1ns
`default_nettype none

module sim_soc_top (
    input  wire logic                clk,
    input  wire logic                rst,

    // host data side
    input  wire logic                req,
    input  wire soc_pkg::bus_req_t   req_data,
    output logic                     ack,
    output soc_pkg::word_t           rdata,

    // instruction fetch, one cycle latency
    input  wire logic                fetch_en,
    input  wire soc_pkg::word_addr_t fetch_addr,
    output soc_pkg::word_t           fetch_data,

    // console
    output logic                     uart_valid,
    output logic [7:0]               uart_byte
);

    // controller to ram
    soc_pkg::mem_port_t mem_port;
    soc_pkg::word_t     mem_rdata;

    // controller to io stub
    logic              io_start;
    soc_pkg::bus_req_t io_req;
    logic              io_done;
    soc_pkg::word_t    io_rdata;

    bus_ctrl i_bus_ctrl (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_data  (req_data),
        .ack       (ack),
        .rdata     (rdata),
        .mem_port  (mem_port),
        .mem_rdata (mem_rdata),
        .io_start  (io_start),
        .io_req    (io_req),
        .io_done   (io_done),
        .io_rdata  (io_rdata)
    );

    // port a for fetch, port b for host data
    byte_en_bram #(
        .DEPTH (soc_pkg::MEM_WORDS)
    ) i_byte_en_bram (
        .clk        (clk),
        .addr_a     (fetch_addr),
        .en_a       (fetch_en),
        .data_out_a (fetch_data),
        .port_b     (mem_port),
        .data_out_b (mem_rdata)
    );

    slow_io_target i_slow_io_target (
        .clk        (clk),
        .rst        (rst),
        .io_start   (io_start),
        .io_req     (io_req),
        .io_done    (io_done),
        .io_rdata   (io_rdata),
        .uart_valid (uart_valid),
        .uart_byte  (uart_byte)
    );

endmodule

`default_nettype wire

// File: test/sim_soc_chk.sv
// handshake and latency assertions for sim_soc_top; assumes the host raises req only while the FSM is in IDLE
`timescale 1ns/1ns
`default_nettype none

module sim_soc_chk (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               req,
    input  wire soc_pkg::bus_req_t  req_data,
    input  wire logic               ack,
    input  wire logic               uart_valid,
    input  wire logic               io_start,
    input  wire logic               io_done,
    input  wire soc_pkg::mem_port_t mem_port
);

    // failed assertions so far, read by the testbench
    int unsigned fail_count = 0;

    // req one edge back, so a rising req marks the sampling edge
    logic req_q;
    // region of the access in flight
    logic in_io;
    logic sample_mem;
    logic sample_io;

    assign sample_mem = req && !req_q && !req_data.addr[soc_pkg::IO_SEL_BIT];
    assign sample_io  = req && !req_q && req_data.addr[soc_pkg::IO_SEL_BIT];

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= 1'b0;
            in_io <= 1'b0;
        end else begin
            req_q <= req;
            if (sample_io) begin
                in_io <= 1'b1;
            end else if (sample_mem) begin
                in_io <= 1'b0;
            end
        end
    end

    // everything quiet once reset has been seen
    reset_quiet: assert property (@(posedge clk)
        rst |=> (!ack && !uart_valid && !io_start && !io_done && !mem_port.en))
        else begin
            $error("outputs not idle after reset");
            fail_count++;
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req))
        else begin
            $error("ack rose without req");
            fail_count++;
        end

    ack_holds: assert property (@(posedge clk) disable iff (rst)
        (ack && req) |=> ack)
        else begin
            $error("ack dropped while req was still high");
            fail_count++;
        end

    ack_releases: assert property (@(posedge clk) disable iff (rst)
        (ack && !req) |=> !ack)
        else begin
            $error("ack did not fall the edge after req fell");
            fail_count++;
        end

    // ack changes on the 3rd edge, so it is sampled high one edge later
    mem_latency: assert property (@(posedge clk) disable iff (rst)
        ($rose(ack) && !in_io) |-> $past(sample_mem, 4))
        else begin
            $error("memory access ack latency is not 3 edges");
            fail_count++;
        end

    io_latency: assert property (@(posedge clk) disable iff (rst)
        ($rose(ack) && in_io) |-> $past(sample_io, soc_pkg::IO_WAIT_CYCLES + 4))
        else begin
            $error("io access ack latency is not IO_WAIT_CYCLES + 3 edges");
            fail_count++;
        end

    // console strobe sits on the io_done of its own access
    uart_with_done: assert property (@(posedge clk) disable iff (rst)
        uart_valid |-> (io_done && $past(io_start, soc_pkg::IO_WAIT_CYCLES)))
        else begin
            $error("uart_valid not IO_WAIT_CYCLES edges after io_start with io_done");
            fail_count++;
        end

endmodule

bind sim_soc_top sim_soc_chk i_sim_soc_chk (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .req_data   (req_data),
    .ack        (ack),
    .uart_valid (uart_valid),
    .io_start   (io_start),
    .io_done    (io_done),
    .mem_port   (mem_port)
);

`default_nettype wire

// File: test/sim_soc_tb.sv
// host and fetch stimulus for sim_soc_top; memory traffic stays in the low 64 words, aliases included
`timescale 1ns/1ns
`default_nettype none

module sim_soc_tb;

    localparam int CYCLE_LIMIT     = 4000;
    localparam int ACK_WAIT_LIMIT  = 40;
    localparam int RANDOM_ACCESSES = 150;
    localparam int MEM_IDX_W       = $clog2(soc_pkg::MEM_WORDS);

    logic                clk;
    logic                rst;
    logic                req;
    soc_pkg::bus_req_t   req_data;
    logic                ack;
    soc_pkg::word_t      rdata;
    logic                fetch_en;
    soc_pkg::word_addr_t fetch_addr;
    soc_pkg::word_t      fetch_data;
    logic                uart_valid;
    logic [7:0]          uart_byte;

    // reference copy of the scratch ram
    soc_pkg::word_t model [soc_pkg::MEM_WORDS];

    // console pulses seen and expected
    int unsigned uart_seen     = 0;
    int unsigned uart_expected = 0;
    logic [7:0]  uart_last;
    logic [7:0]  uart_last_expected;

    int unsigned cycles = 0;

    sim_soc_top i_sim_soc_top (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_data   (req_data),
        .ack        (ack),
        .rdata      (rdata),
        .fetch_en   (fetch_en),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .uart_valid (uart_valid),
        .uart_byte  (uart_byte)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50;
            clk = ~clk;
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            abort_run("run exceeded the cycle limit");
        end
    end

    // a strobe spans one whole cycle, so exactly one negedge sees it
    always @(negedge clk) begin
        if (!rst && uart_valid) begin
            uart_seen++;
            uart_last = uart_byte;
        end
        if (i_sim_soc_top.i_sim_soc_chk.fail_count != 0) begin
            abort_run("an assertion in the bound checker failed");
        end
    end

    task automatic abort_run(input string why);
        $display("%s at time %0t", why, $time);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAILED at time %0t: %s expected %h actual %h", $time, name, expected, actual);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // enabled lanes take the new byte, the rest keep the old one
    function automatic soc_pkg::word_t merge_lanes(input soc_pkg::word_t old_word,
                                                   input soc_pkg::word_t new_word,
                                                   input soc_pkg::byte_en_t be);
        soc_pkg::word_t mask;
        for (int lane = 0; lane < soc_pkg::BYTE_LANES; lane++) begin
            mask[lane*8 +: 8] = {8{be[lane]}};
        end
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // one full four-phase cycle
    task automatic host_access(input soc_pkg::word_addr_t addr, input soc_pkg::word_t wdata,
                               input soc_pkg::byte_en_t be, input logic write,
                               output soc_pkg::word_t got);
        int waited;
        @(negedge clk);
        req      = 1'b1;
        req_data = '{addr: addr, wdata: wdata, be: be, write: write};
        waited   = 0;
        while (!ack) begin
            @(negedge clk);
            waited++;
            if (waited > ACK_WAIT_LIMIT) begin
                abort_run("bus controller never raised ack");
            end
        end
        got    = rdata;
        req    = 1'b0;
        waited = 0;
        while (ack) begin
            @(negedge clk);
            waited++;
            if (waited > ACK_WAIT_LIMIT) begin
                abort_run("bus controller never dropped ack");
            end
        end
    endtask

    task automatic check_console();
        assert (uart_seen == uart_expected)
            else report_mismatch("uart_valid pulse count", uart_expected, uart_seen);
        if (uart_expected != 0) begin
            assert (uart_last == uart_last_expected)
                else report_mismatch("uart_byte", {24'h0, uart_last_expected}, {24'h0, uart_last});
        end
    endtask

    task automatic mem_access(input soc_pkg::word_addr_t addr, input soc_pkg::word_t wdata,
                              input soc_pkg::byte_en_t be, input logic write);
        soc_pkg::word_t         got;
        logic [MEM_IDX_W-1:0]   idx;
        idx = addr[MEM_IDX_W-1:0];
        host_access(addr, wdata, be, write, got);
        if (write) begin
            model[idx] = merge_lanes(model[idx], wdata, be);
        end else begin
            assert (got == model[idx]) else report_mismatch("rdata", model[idx], got);
        end
        // memory writes never reach the console
        check_console();
    endtask

    task automatic io_access(input soc_pkg::word_addr_t addr, input soc_pkg::word_t wdata,
                             input logic write);
        soc_pkg::word_t got;
        host_access(addr, wdata, 4'hF, write, got);
        if (!write) begin
            assert (got == soc_pkg::IO_READ_PATTERN)
                else report_mismatch("rdata", soc_pkg::IO_READ_PATTERN, got);
        end else if (addr[13:0] == soc_pkg::UART_WORD_OFFSET) begin
            uart_expected++;
            uart_last_expected = wdata[7:0];
        end
        check_console();
    endtask

    // data lands on the edge after fetch_en
    task automatic fetch_check(input soc_pkg::word_addr_t addr);
        @(negedge clk);
        fetch_en   = 1'b1;
        fetch_addr = addr;
        @(negedge clk);
        fetch_en = 1'b0;
        assert (fetch_data == model[addr[MEM_IDX_W-1:0]])
            else report_mismatch("fetch_data", model[addr[MEM_IDX_W-1:0]], fetch_data);
    endtask

    initial begin
        logic [31:0]         seed_ret;
        logic [31:0]         pick;
        logic [31:0]         addr_rnd;
        logic [31:0]         data_rnd;
        soc_pkg::word_addr_t mem_addr;
        soc_pkg::word_addr_t io_addr;

        seed_ret = $urandom(32'h3853);
        for (int i = 0; i < soc_pkg::MEM_WORDS; i++) begin
            model[i] = '0;
        end
        rst        = 1'b1;
        req        = 1'b0;
        req_data   = '0;
        fetch_en   = 1'b0;
        fetch_addr = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // zero fill, full and partial lane writes
        mem_access(16'h0005, 32'h0, 4'h0, 1'b0);
        mem_access(16'h0010, 32'hA1B2C3D4, 4'hF, 1'b1);
        mem_access(16'h0010, 32'h11223344, 4'b0101, 1'b1);
        mem_access(16'h0010, 32'h0, 4'h0, 1'b0);
        // bit 10 aliases onto word 0x10, 0x0400 onto word 0
        mem_access(16'h0410, 32'h55667788, 4'b1000, 1'b1);
        mem_access(16'h0400, 32'h000000AA, 4'b0001, 1'b1);
        mem_access(16'h0010, 32'h0, 4'h0, 1'b0);
        mem_access(16'h0000, 32'h0, 4'h0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            data_rnd = $urandom();
            pick     = $urandom();
            mem_access(soc_pkg::word_addr_t'(32 + i), data_rnd, pick[3:0], 1'b1);
        end
        for (int i = 0; i < 8; i++) begin
            mem_access(soc_pkg::word_addr_t'(32 + i), 32'h0, 4'h0, 1'b0);
            fetch_check(soc_pkg::word_addr_t'(32 + i));
        end
        fetch_check(16'h0010);
        fetch_check(16'h0030);

        // io reads, then console and non-console io writes
        io_access(16'h8000, 32'h0, 1'b0);
        io_access(16'hC123, 32'h0, 1'b0);
        io_access(16'h8400, 32'h0, 1'b0);
        io_access(16'h8400, 32'h12345648, 1'b1);
        io_access(16'hC400, 32'h00000069, 1'b1);
        io_access(16'h8001, 32'h00000021, 1'b1);
        io_access(16'h83FF, 32'h0000003F, 1'b1);

        // random mix over both regions, gaps and fetches
        for (int n = 0; n < RANDOM_ACCESSES; n++) begin
            pick     = $urandom();
            addr_rnd = $urandom();
            data_rnd = $urandom();
            mem_addr = {1'b0, addr_rnd[14:10], 4'b0000, addr_rnd[5:0]};
            io_addr  = {1'b1, addr_rnd[14],
                        (pick[6:5] == 2'b00) ? soc_pkg::UART_WORD_OFFSET : addr_rnd[13:0]};
            repeat (pick[1:0]) @(negedge clk);
            case (pick[4:2])
                3'd0, 3'd1, 3'd2: mem_access(mem_addr, data_rnd, pick[10:7], 1'b1);
                3'd3, 3'd4:       mem_access(mem_addr, 32'h0, 4'h0, 1'b0);
                3'd5:             io_access(io_addr, 32'h0, 1'b0);
                3'd6:             io_access(io_addr, data_rnd, 1'b1);
                default:          fetch_check(mem_addr);
            endcase
            if (pick[11]) begin
                fetch_check(mem_addr);
            end
        end

        repeat (4) @(negedge clk);
        if (i_sim_soc_top.i_sim_soc_chk.fail_count != 0) begin
            abort_run("an assertion in the bound checker failed");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: compile.f
common/soc_pkg.sv
bram/byte_en_bram.sv
source/slow_io_target.sv
source/bus_ctrl.sv
source/sim_soc_top.sv
test/sim_soc_chk.sv
test/sim_soc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the sim_soc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module sim_soc_tb \
    -f compile.f \
    -o sim_soc_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_soc_tb +verilator+error+limit+100)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "All tests passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
